// File: source/csa_pkg.sv
package csa_pkg;

	// bus and memory geometry
	localparam int DATA_W = 32;
	localparam int SLOT_NUM = 8;
	localparam int SLOT_WORDS = 16;
	localparam int SLOT_W = $clog2(SLOT_NUM);
	localparam int OFS_W = $clog2(SLOT_WORDS);
	localparam int ADDR_W = SLOT_W + OFS_W; // 128 words
	localparam int ROUND_W = 8;

	// word offsets inside a slot
	localparam logic [OFS_W-1:0] OFS_CTRL = OFS_W'(0);
	localparam logic [OFS_W-1:0] OFS_BLOCK = OFS_W'(1);
	localparam logic [OFS_W-1:0] OFS_KEY_LO = OFS_W'(2);
	localparam logic [OFS_W-1:0] OFS_KEY_HI = OFS_W'(3); // low 16 bits only
	localparam logic [OFS_W-1:0] OFS_ROUNDS = OFS_W'(4);
	localparam logic [OFS_W-1:0] OFS_OUT_LO = OFS_W'(8);
	localparam logic [OFS_W-1:0] OFS_OUT_HI = OFS_W'(9);
	localparam logic [OFS_W-1:0] OFS_OUT_BLOCK = OFS_W'(10);

	// control word bits
	localparam int CTRL_START = 0; // host sets, engine clears
	localparam int CTRL_DONE = 1; // engine sets

	// keystream round
	localparam logic [63:0] ROUND_ADD = 64'h9E37_79B9_7F4A_7C15;
	localparam int ROUND_ROT = 5;

	typedef enum logic [2:0] {
		ES_SCAN,
		ES_LOAD,
		ES_CALC,
		ES_STORE,
		ES_FINISH
	} engine_state_t;

endpackage

// File: source/csa_job_ram.sv
`timescale 1ns/10ps

module csa_job_ram
	import csa_pkg::*;
(
	input  logic axi_mm_clk,
	input  logic rst_n,
	input  logic cyc_i,
	input  logic stb_i,
	input  logic we_i,
	input  logic [ADDR_W-1:0] adr_i,
	input  logic [DATA_W-1:0] dat_i,
	output logic [DATA_W-1:0] dat_o,
	output logic ack_o
);

	logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];
	logic req;

	// ack drops after each transfer, so a held strobe is not served twice
	assign req = cyc_i && stb_i && !ack_o;

	initial begin
		for (int i = 0; i < (1 << ADDR_W); i++) begin
			mem[i] = '0; // power-up contents
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= req;
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (req && we_i) begin
			mem[adr_i] <= dat_i;
		end
		if (req) begin
			dat_o <= mem[adr_i]; // valid together with ack
		end
	end

endmodule

// File: source/csa_bus_arbiter.sv
`timescale 1ns/10ps

module csa_bus_arbiter
	import csa_pkg::*;
(
	input  logic axi_mm_clk,
	input  logic rst_n,

	input  logic m0_cyc_i,
	input  logic m0_stb_i,
	input  logic m0_we_i,
	input  logic [ADDR_W-1:0] m0_adr_i,
	input  logic [DATA_W-1:0] m0_dat_i,
	output logic [DATA_W-1:0] m0_dat_o,
	output logic m0_ack_o,

	input  logic m1_cyc_i,
	input  logic m1_stb_i,
	input  logic m1_we_i,
	input  logic [ADDR_W-1:0] m1_adr_i,
	input  logic [DATA_W-1:0] m1_dat_i,
	output logic [DATA_W-1:0] m1_dat_o,
	output logic m1_ack_o,

	output logic s_cyc_o,
	output logic s_stb_o,
	output logic s_we_o,
	output logic [ADDR_W-1:0] s_adr_o,
	output logic [DATA_W-1:0] s_dat_o,
	input  logic [DATA_W-1:0] s_dat_i,
	input  logic s_ack_i
);

	logic [1:0] gnt; // one-hot owner, zero when idle
	logic last_gnt; // 1 when master 1 owned the bus last

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			gnt <= 2'b00;
			last_gnt <= 1'b1; // host wins the first tie
		end else if (gnt == 2'b00) begin
			if (m0_cyc_i && (!m1_cyc_i || last_gnt)) begin
				gnt <= 2'b01;
				last_gnt <= 1'b0;
			end else if (m1_cyc_i) begin
				gnt <= 2'b10;
				last_gnt <= 1'b1;
			end
		end else if ((gnt[0] && !m0_cyc_i) || (gnt[1] && !m1_cyc_i)) begin
			gnt <= 2'b00; // owner released the bus
		end
	end

	always_comb begin
		s_cyc_o = 1'b0;
		s_stb_o = 1'b0;
		s_we_o = 1'b0;
		s_adr_o = m0_adr_i;
		s_dat_o = m0_dat_i;
		if (gnt[0]) begin
			s_cyc_o = m0_cyc_i;
			s_stb_o = m0_stb_i;
			s_we_o = m0_we_i;
		end else if (gnt[1]) begin
			s_cyc_o = m1_cyc_i;
			s_stb_o = m1_stb_i;
			s_we_o = m1_we_i;
			s_adr_o = m1_adr_i;
			s_dat_o = m1_dat_i;
		end
	end

	// read data goes to both, ack only to the owner
	assign m0_dat_o = s_dat_i;
	assign m1_dat_o = s_dat_i;
	assign m0_ack_o = s_ack_i && gnt[0];
	assign m1_ack_o = s_ack_i && gnt[1];

endmodule

// File: source/csa_round_core.sv
`timescale 1ns/10ps

module csa_round_core
	import csa_pkg::*;
(
	input  logic axi_mm_clk,
	input  logic rst_n,
	input  logic start_i,
	input  logic [DATA_W-1:0] block_i,
	input  logic [DATA_W-1:0] key_lo_i,
	input  logic [DATA_W-1:0] key_hi_i,
	input  logic [ROUND_W-1:0] rounds_i,
	output logic [63:0] result_o,
	output logic busy_o,
	output logic done_o
);

	logic [63:0] state_q;
	logic [63:0] init_state;
	logic [63:0] state_rot;
	logic [ROUND_W-1:0] cnt_q;

	// block id on top, 48-bit key below
	assign init_state = {block_i[15:0], key_hi_i[15:0], key_lo_i};
	assign state_rot = {state_q[63-ROUND_ROT:0], state_q[63:64-ROUND_ROT]};
	assign result_o = state_q;

	always_ff @(posedge axi_mm_clk) begin
		if (start_i) begin
			state_q <= init_state;
		end else if (busy_o) begin
			state_q <= state_rot + ROUND_ADD; // wraps mod 2^64
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			busy_o <= 1'b0;
			done_o <= 1'b0;
			cnt_q <= '0;
		end else begin
			done_o <= 1'b0;
			if (start_i) begin
				cnt_q <= rounds_i;
				busy_o <= (rounds_i != '0);
				done_o <= (rounds_i == '0); // zero rounds done next cycle
			end else if (busy_o) begin
				cnt_q <= cnt_q - 1'b1;
				if (cnt_q == ROUND_W'(1)) begin
					busy_o <= 1'b0;
					done_o <= 1'b1;
				end
			end
		end
	end

endmodule

// File: source/csa_job_engine.sv
`timescale 1ns/10ps

module csa_job_engine
	import csa_pkg::*;
(
	input  logic axi_mm_clk,
	input  logic rst_n,
	output logic cyc_o,
	output logic stb_o,
	output logic we_o,
	output logic [ADDR_W-1:0] adr_o,
	output logic [DATA_W-1:0] dat_o,
	input  logic [DATA_W-1:0] dat_i,
	input  logic ack_i
);

	engine_state_t state_q;
	logic [SLOT_W-1:0] slot_q;
	logic [1:0] wcnt_q; // word within the load or store burst
	logic [DATA_W-1:0] block_q;
	logic [DATA_W-1:0] key_lo_q;
	logic [DATA_W-1:0] key_hi_q;
	logic [ROUND_W-1:0] rounds_q;
	logic core_start;
	logic core_done;
	logic [63:0] core_result;
	logic req_vld;
	logic req_we;
	logic [OFS_W-1:0] req_ofs;
	logic [DATA_W-1:0] req_dat;
	logic xfer_done;

	assign stb_o = cyc_o; // cyc spans exactly one transfer
	assign xfer_done = cyc_o && ack_i;

	// next transfer for the current state
	always_comb begin
		req_vld = 1'b1;
		req_we = 1'b0;
		req_ofs = OFS_CTRL;
		req_dat = '0;
		case (state_q)
			ES_LOAD: begin
				case (wcnt_q)
					2'd0: req_ofs = OFS_BLOCK;
					2'd1: req_ofs = OFS_KEY_LO;
					2'd2: req_ofs = OFS_KEY_HI;
					default: req_ofs = OFS_ROUNDS;
				endcase
			end
			ES_CALC: req_vld = 1'b0;
			ES_STORE: begin
				req_we = 1'b1;
				case (wcnt_q)
					2'd0: begin
						req_ofs = OFS_OUT_LO;
						req_dat = core_result[31:0];
					end
					2'd1: begin
						req_ofs = OFS_OUT_HI;
						req_dat = core_result[63:32];
					end
					default: begin
						req_ofs = OFS_OUT_BLOCK;
						req_dat = block_q; // echoed block id
					end
				endcase
			end
			ES_FINISH: begin
				req_we = 1'b1;
				req_dat = DATA_W'(1) << CTRL_DONE; // start cleared
			end
			default: req_ofs = OFS_CTRL;
		endcase
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			cyc_o <= 1'b0;
		end else if (xfer_done) begin
			cyc_o <= 1'b0; // idle for at least one cycle
		end else if (!cyc_o && req_vld) begin
			cyc_o <= 1'b1;
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!cyc_o) begin
			we_o <= req_we;
			adr_o <= {slot_q, req_ofs};
			dat_o <= req_dat;
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			state_q <= ES_SCAN;
			slot_q <= '0;
			wcnt_q <= '0;
			core_start <= 1'b0;
		end else begin
			core_start <= 1'b0;
			case (state_q)
				ES_SCAN: begin
					if (xfer_done) begin
						if (dat_i[CTRL_START]) begin
							state_q <= ES_LOAD;
							wcnt_q <= '0;
						end else begin
							slot_q <= slot_q + 1'b1; // skip idle slot
						end
					end
				end
				ES_LOAD: begin
					if (xfer_done) begin
						wcnt_q <= wcnt_q + 1'b1;
						if (wcnt_q == 2'd3) begin
							core_start <= 1'b1;
							state_q <= ES_CALC;
						end
					end
				end
				ES_CALC: begin
					if (core_done) begin
						state_q <= ES_STORE;
						wcnt_q <= '0;
					end
				end
				ES_STORE: begin
					if (xfer_done) begin
						wcnt_q <= wcnt_q + 1'b1;
						if (wcnt_q == 2'd2) begin
							state_q <= ES_FINISH;
						end
					end
				end
				ES_FINISH: begin
					if (xfer_done) begin
						state_q <= ES_SCAN;
						slot_q <= slot_q + 1'b1;
					end
				end
				default: state_q <= ES_SCAN;
			endcase
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (state_q == ES_LOAD && xfer_done) begin
			case (wcnt_q)
				2'd0: block_q <= dat_i;
				2'd1: key_lo_q <= dat_i;
				2'd2: key_hi_q <= dat_i;
				default: rounds_q <= dat_i[ROUND_W-1:0]; // upper bits ignored
			endcase
		end
	end

	csa_round_core u_core (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.start_i(core_start),
		.block_i(block_q),
		.key_lo_i(key_lo_q),
		.key_hi_i(key_hi_q),
		.rounds_i(rounds_q),
		.result_o(core_result),
		.busy_o(),
		.done_o(core_done)
	);

endmodule

// File: source/csa_subsystem_top.sv
`timescale 1ns/10ps

module csa_subsystem_top
	import csa_pkg::*;
(
	input  logic axi_mm_clk,
	input  logic rst_n,
	input  logic host_cyc_i,
	input  logic host_stb_i,
	input  logic host_we_i,
	input  logic [ADDR_W-1:0] host_adr_i,
	input  logic [DATA_W-1:0] host_dat_i,
	output logic [DATA_W-1:0] host_dat_o,
	output logic host_ack_o
);

	// engine master
	logic eng_cyc;
	logic eng_stb;
	logic eng_we;
	logic [ADDR_W-1:0] eng_adr;
	logic [DATA_W-1:0] eng_dat_w;
	logic [DATA_W-1:0] eng_dat_r;
	logic eng_ack;

	// memory side
	logic mem_cyc;
	logic mem_stb;
	logic mem_we;
	logic [ADDR_W-1:0] mem_adr;
	logic [DATA_W-1:0] mem_dat_w;
	logic [DATA_W-1:0] mem_dat_r;
	logic mem_ack;

	csa_bus_arbiter u_arbiter (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.m0_cyc_i(host_cyc_i),
		.m0_stb_i(host_stb_i),
		.m0_we_i(host_we_i),
		.m0_adr_i(host_adr_i),
		.m0_dat_i(host_dat_i),
		.m0_dat_o(host_dat_o),
		.m0_ack_o(host_ack_o),
		.m1_cyc_i(eng_cyc),
		.m1_stb_i(eng_stb),
		.m1_we_i(eng_we),
		.m1_adr_i(eng_adr),
		.m1_dat_i(eng_dat_w),
		.m1_dat_o(eng_dat_r),
		.m1_ack_o(eng_ack),
		.s_cyc_o(mem_cyc),
		.s_stb_o(mem_stb),
		.s_we_o(mem_we),
		.s_adr_o(mem_adr),
		.s_dat_o(mem_dat_w),
		.s_dat_i(mem_dat_r),
		.s_ack_i(mem_ack)
	);

	csa_job_ram u_ram (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.cyc_i(mem_cyc),
		.stb_i(mem_stb),
		.we_i(mem_we),
		.adr_i(mem_adr),
		.dat_i(mem_dat_w),
		.dat_o(mem_dat_r),
		.ack_o(mem_ack)
	);

	csa_job_engine u_engine (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.cyc_o(eng_cyc),
		.stb_o(eng_stb),
		.we_o(eng_we),
		.adr_o(eng_adr),
		.dat_o(eng_dat_w),
		.dat_i(eng_dat_r),
		.ack_i(eng_ack)
	);

endmodule

// File: dv/csa_tb_model.svh
`ifndef CSA_TB_MODEL_SVH
`define CSA_TB_MODEL_SVH

// expected job memory as the host should see it
logic [DATA_W-1:0] shadow_mem [0:(1<<ADDR_W)-1];

function automatic void clear_shadow();
	for (int i = 0; i < (1 << ADDR_W); i++) begin
		shadow_mem[i] = '0; // matches power-up contents
	end
endfunction

function automatic logic [ADDR_W-1:0] slot_addr(input int slot, input int ofs);
	return ADDR_W'(slot * SLOT_WORDS + ofs);
endfunction

function automatic logic [63:0] keystream_ref(input logic [DATA_W-1:0] block,
		input logic [DATA_W-1:0] key_lo, input logic [DATA_W-1:0] key_hi,
		input logic [DATA_W-1:0] rounds_word);
	logic [63:0] s;
	int n;
	s = {block[15:0], key_hi[15:0], key_lo};
	n = rounds_word[ROUND_W-1:0]; // upper bits of the word ignored
	for (int r = 0; r < n; r++) begin
		s = ((s << ROUND_ROT) | (s >> (64 - ROUND_ROT))) + ROUND_ADD;
	end
	return s;
endfunction

// slot image after the engine has written back the job in this slot
function automatic void finish_slot(input int slot);
	logic [63:0] res;
	res = keystream_ref(shadow_mem[slot_addr(slot, OFS_BLOCK)],
		shadow_mem[slot_addr(slot, OFS_KEY_LO)],
		shadow_mem[slot_addr(slot, OFS_KEY_HI)],
		shadow_mem[slot_addr(slot, OFS_ROUNDS)]);
	shadow_mem[slot_addr(slot, OFS_OUT_LO)] = res[31:0];
	shadow_mem[slot_addr(slot, OFS_OUT_HI)] = res[63:32];
	shadow_mem[slot_addr(slot, OFS_OUT_BLOCK)] = shadow_mem[slot_addr(slot, OFS_BLOCK)];
	shadow_mem[slot_addr(slot, OFS_CTRL)] = DATA_W'(1) << CTRL_DONE;
endfunction

`endif

// File: dv/csa_tb.sv
`timescale 1ns/10ps

module csa_tb
	import csa_pkg::*;
();

	localparam int JOB_COUNT = 17; // jobs over all tests
	localparam int WATCHDOG_CYCLES = JOB_COUNT * (256 + 40) + 5000;

	logic axi_mm_clk = 1'b0;
	logic rst_n;
	logic host_cyc_i;
	logic host_stb_i;
	logic host_we_i;
	logic [ADDR_W-1:0] host_adr_i;
	logic [DATA_W-1:0] host_dat_i;
	logic [DATA_W-1:0] host_dat_o;
	logic host_ack_o;
	int value_errs = 0;
	int other_errs = 0;

	`include "csa_tb_model.svh"

	always #4 axi_mm_clk = ~axi_mm_clk;

	csa_subsystem_top DUT (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.host_cyc_i(host_cyc_i),
		.host_stb_i(host_stb_i),
		.host_we_i(host_we_i),
		.host_adr_i(host_adr_i),
		.host_dat_i(host_dat_i),
		.host_dat_o(host_dat_o),
		.host_ack_o(host_ack_o)
	);

	task automatic bus_transfer(input logic we, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
		@(posedge axi_mm_clk);
		#1;
		host_cyc_i = 1'b1;
		host_stb_i = 1'b1;
		host_we_i = we;
		host_adr_i = addr;
		host_dat_i = wdata;
		do begin
			@(posedge axi_mm_clk);
			#1;
		end while (!host_ack_o); // latency depends on the engine
		rdata = host_dat_o;
		host_cyc_i = 1'b0;
		host_stb_i = 1'b0;
		host_we_i = 1'b0;
	endtask

	task automatic wb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] unused;
		bus_transfer(1'b1, addr, data, unused);
		shadow_mem[addr] = data;
	endtask

	task automatic wb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		bus_transfer(1'b0, addr, '0, data);
	endtask

	task automatic read_check(input logic [ADDR_W-1:0] addr);
		logic [DATA_W-1:0] got;
		wb_read(addr, got);
		assert (got === shadow_mem[addr]) else begin
			value_errs++;
			$display("error: host_dat_o at address %h expected %h actual %h",
				addr, shadow_mem[addr], got);
		end
	endtask

	task automatic load_job(input int slot, input logic [DATA_W-1:0] rounds_word);
		wb_write(slot_addr(slot, OFS_BLOCK), $urandom());
		wb_write(slot_addr(slot, OFS_KEY_LO), $urandom());
		wb_write(slot_addr(slot, OFS_KEY_HI), $urandom()); // upper half ignored
		wb_write(slot_addr(slot, OFS_ROUNDS), rounds_word);
	endtask

	task automatic start_job(input int slot);
		wb_write(slot_addr(slot, OFS_CTRL), DATA_W'(1) << CTRL_START); // done cleared
	endtask

	// poll until done, then check the whole used part of the slot
	task automatic finish_and_check(input int slot);
		logic [DATA_W-1:0] ctrl;
		ctrl = '0;
		while (!ctrl[CTRL_DONE]) begin
			wb_read(slot_addr(slot, OFS_CTRL), ctrl);
		end
		finish_slot(slot);
		for (int ofs = 0; ofs <= OFS_OUT_BLOCK; ofs++) begin
			read_check(slot_addr(slot, ofs));
		end
	endtask

	initial begin
		logic [ADDR_W-1:0] addr;
		void'($urandom(32'h5d0e_e3ae));
		rst_n = 1'b0;
		host_cyc_i = 1'b0;
		host_stb_i = 1'b0;
		host_we_i = 1'b0;
		host_adr_i = '0;
		host_dat_i = '0;
		clear_shadow();
		repeat (8) @(posedge axi_mm_clk);
		#1;
		rst_n = 1'b1;
		assert (host_ack_o === 1'b0) else begin
			other_errs++;
			$display("host ack is high right after reset");
		end
		repeat (100) @(posedge axi_mm_clk); // engine scans empty slots
		for (int s = 0; s < SLOT_NUM; s++) begin
			read_check(slot_addr(s, OFS_CTRL));
		end

		load_job(0, $urandom());
		start_job(0);
		finish_and_check(0);

		for (int s = 0; s < SLOT_NUM; s++) begin
			load_job(s, $urandom());
		end
		for (int s = 0; s < SLOT_NUM; s++) begin
			start_job(s);
		end
		for (int s = 0; s < SLOT_NUM; s++) begin
			finish_and_check(s);
		end

		// edge round counts
		load_job(5, 32'd0);
		load_job(6, 32'd1);
		load_job(7, 32'd255);
		for (int s = 5; s < SLOT_NUM; s++) begin
			start_job(s);
		end
		for (int s = 5; s < SLOT_NUM; s++) begin
			finish_and_check(s);
		end

		// host traffic on slots 4..7 while 0..3 run, control words left alone
		for (int s = 0; s < 4; s++) begin
			load_job(s, $urandom());
			start_job(s);
		end
		for (int i = 0; i < 40; i++) begin
			addr = slot_addr(4 + $urandom_range(3), 1 + $urandom_range(14));
			if ($urandom_range(1)) begin
				wb_write(addr, $urandom());
			end else begin
				read_check(addr);
			end
		end
		for (int s = 0; s < 4; s++) begin
			finish_and_check(s);
		end

		load_job(2, $urandom()); // new job over a done slot
		start_job(2);
		finish_and_check(2);

		$display("summary: %0d value errors, %0d other errors", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge axi_mm_clk);
		other_errs++;
		$display("timeout: run did not complete within %0d cycles", WATCHDOG_CYCLES);
		$display("summary: %0d value errors, %0d other errors", value_errs, other_errs);
		$display("Something failed");
		$finish;
	end

endmodule

// File: files.f
+incdir+dv
source/csa_pkg.sv
source/csa_job_ram.sv
source/csa_bus_arbiter.sv
source/csa_round_core.sv
source/csa_job_engine.sv
source/csa_subsystem_top.sv
dv/csa_tb.sv
